/* verilog.f */
+incdir+hw
hw/cvpPkg.sv
hw/vectorRegFile.sv
hw/scalarRegFile.sv
hw/halfFloatAdd.sv
hw/cvpController.sv
hw/cvpCore.sv
sim/testMemory.sv
sim/cvpCoreTb.sv

/* Bender.yml */
package:
  name: cvp_core

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/cvpPkg.sv
      - hw/vectorRegFile.sv
      - hw/scalarRegFile.sv
      - hw/halfFloatAdd.sv
      - hw/cvpController.sv
      - hw/cvpCore.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/testMemory.sv
      - sim/cvpCoreTb.sv

/* sim/cvpCoreTb.sv */
`timescale 1ns/10ps
`include "cvp_defines.svh"

module cvpCoreTb import cvpPkg::*;;

  localparam int clkPeriod   = 4;
  localparam int resetCycles = 8;
  localparam int watchdogNs  = 40 * 9 * clkPeriod + resetCycles * clkPeriod;

  localparam logic [`WORD_W-1:0] dataBase = 16'h0100; // Program sits below
  localparam logic [`WORD_W-1:0] haltAddr = 16'd23;

  // Lane 0 in the low bits
  localparam logic [`VEC_W-1:0] addLhs = {16'h3C01, 16'h0200, 16'h3C00, 16'h3C00};
  localparam logic [`VEC_W-1:0] addRhs = {16'h1000, 16'h0200, 16'hBC00, 16'h4000};
  // 1+2=3, cancel to +0, two subnormals, tie rounded to even
  localparam logic [`VEC_W-1:0] addSum = {16'h3C02, 16'h0400, 16'h0000, 16'h4200};

  typedef struct packed {
    logic [`WORD_W-1:0] addr;
    logic               v;    // V seen from this fetch on
  } fetchT;

  typedef struct packed {
    logic [`WORD_W-1:0] addr;
    logic [`WORD_W-1:0] data;
  } writeT;

  logic               Clk1 = 1'b0;
  logic               reset;
  logic [`WORD_W-1:0] DataIn;
  logic [`WORD_W-1:0] Addr;
  logic [`WORD_W-1:0] dataOut;
  logic               RD;
  logic               WR;
  logic               V;

  int    seed;
  logic  vNow = 1'b0;
  int    haltFetches = 0;
  fetchT fetchQ[$];
  string fetchNameQ[$];
  writeT writeQ[$];
  string writeNameQ[$];

  always #(clkPeriod / 2) Clk1 = ~Clk1;

  cvpCore u_cvpCore (
    .Clk1    (Clk1),
    .reset   (reset),
    .DataIn  (DataIn),
    .Addr    (Addr),
    .dataOut (dataOut),
    .RD      (RD),
    .WR      (WR),
    .V       (V)
  );

  testMemory u_testMemory (
    .Clk1   (Clk1),
    .addr   (Addr),
    .rd     (RD),
    .wr     (WR),
    .wrData (dataOut),
    .rdData (DataIn)
  );

  task automatic failRun(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1, "Stopped at first failure");
  endtask

  task automatic checkValue(input string testName, input logic [`WORD_W-1:0] expected,
                            input logic [`WORD_W-1:0] actual);
    assert (actual === expected)
      else failRun($sformatf("** Error: %s expected %h actual %h", testName, expected, actual));
  endtask

  function automatic logic [`WORD_W-1:0] regOp(input opcodeT op, input int dst,
                                               input int src1, input int src2);
    return {op, 3'(dst), 3'(src1), 3'(src2), 3'b000};
  endfunction

  function automatic logic [`WORD_W-1:0] immOp(input opcodeT op, input int dst,
                                               input logic [7:0] imm);
    return {op, 3'(dst), 1'b0, imm};
  endfunction

  // Base register plus zero-extended offset
  function automatic logic [`WORD_W-1:0] memOp(input opcodeT op, input int dst,
                                               input int src1, input int offset);
    return {op, 3'(dst), 3'(src1), 6'(offset)};
  endfunction

  function automatic logic [`WORD_W-1:0] jumpOp(input int offset);
    return {J, 12'(offset)};
  endfunction

  task automatic preload(input logic [`WORD_W-1:0] a, input logic [`WORD_W-1:0] d);
    u_testMemory.loadWord(a, d);
  endtask

  task automatic expectFetch(input string name, input logic [`WORD_W-1:0] a, input logic v);
    fetchQ.push_back('{addr: a, v: v});
    fetchNameQ.push_back(name);
  endtask

  task automatic expectWrite(input string name, input logic [`WORD_W-1:0] a,
                             input logic [`WORD_W-1:0] d);
    writeQ.push_back('{addr: a, data: d});
    writeNameQ.push_back(name);
  endtask

  task automatic loadProgram();
    logic [`WORD_W-1:0] copyWord;
    u_testMemory.fill();
    preload(0, immOp(SLH, 1, 8'h12));
    preload(1, immOp(SLL, 1, 8'h34));  // s1 = 1234
    preload(2, immOp(SLH, 2, 8'h02));  // s2 = 0200, store base
    preload(3, memOp(SST, 1, 2, 0));
    preload(4, memOp(SST, 1, 2, 5));
    preload(5, immOp(SLH, 3, 8'h01));  // s3 = 0100, load base
    preload(6, memOp(VLD, 1, 3, 2));
    preload(7, memOp(VST, 1, 2, 6'h10));
    preload(8, memOp(VLD, 2, 3, 6'h10));
    preload(9, memOp(VLD, 3, 3, 6'h14));
    preload(10, regOp(VADD, 4, 2, 3));
    preload(11, memOp(VST, 4, 2, 6'h20));
    preload(12, memOp(VLD, 5, 3, 6'h18));
    preload(13, regOp(VADD, 6, 5, 5)); // Overflows every lane
    preload(14, memOp(VST, 6, 2, 6'h24));
    preload(15, regOp(VADD, 7, 2, 3)); // Clean add clears V
    preload(16, jumpOp(4));
    preload(17, memOp(SST, 1, 2, 6'h30)); // Bypassed, would store
    preload(18, 16'hF000);
    preload(19, jumpOp(3));
    preload(20, jumpOp(-2));
    preload(21, memOp(SST, 1, 2, 6'h30)); // Bypassed too
    preload(22, 16'hF000);
    preload(haltAddr, jumpOp(0));

    expectWrite("scalarBuild", 16'h0200, 16'h1234);
    expectWrite("scalarBuild", 16'h0205, 16'h1234);
    for (int i = 0; i < `VEC_LEN; i++) begin
      copyWord = 16'($random(seed));
      preload(16'h0102 + 16'(i), copyWord);
      expectWrite("vectorCopy", 16'h0210 + 16'(i), copyWord);
    end
    for (int i = 0; i < `VEC_LEN; i++) begin
      preload(16'h0110 + 16'(i), addLhs[i*`WORD_W +: `WORD_W]);
      preload(16'h0114 + 16'(i), addRhs[i*`WORD_W +: `WORD_W]);
      preload(16'h0118 + 16'(i), 16'h7BFF); // Largest finite value
      expectWrite("vectorAdd", 16'h0220 + 16'(i), addSum[i*`WORD_W +: `WORD_W]);
    end
    for (int i = 0; i < `VEC_LEN; i++) begin
      expectWrite("overflowFlag", 16'h0224 + 16'(i), `HALF_INF);
    end

    // Straight line up to the first J, V high after the overflowing VADD
    for (int a = 0; a <= 16; a++) begin
      expectFetch(a == 0 ? "resetFetch" : "fetchOrder", 16'(a), a == 14 || a == 15);
    end
    expectFetch("jump", 16'd20, 1'b0);
    expectFetch("jump", 16'd18, 1'b0);
    expectFetch("jump", 16'd19, 1'b0);
    expectFetch("jump", 16'd22, 1'b0);
    expectFetch("jump", haltAddr, 1'b0);
  endtask

  always @(negedge Clk1) begin : monitor
    fetchT expFetch;
    writeT expWrite;
    string name;
    if (!reset) begin
      if (RD && Addr < dataBase) begin
        if (fetchQ.size() > 0) begin
          expFetch = fetchQ.pop_front();
          name     = fetchNameQ.pop_front();
          checkValue(name, expFetch.addr, Addr);
          vNow = expFetch.v;
        end else begin
          checkValue("jump", haltAddr, Addr); // Parked in the halt loop
          haltFetches++;
        end
      end
      if (WR) begin
        if (writeQ.size() == 0) begin
          failRun($sformatf("Unexpected memory write of %h to address %h", dataOut, Addr));
        end else begin
          expWrite = writeQ.pop_front();
          name     = writeNameQ.pop_front();
          checkValue({name, " addr"}, expWrite.addr, Addr);
          checkValue({name, " data"}, expWrite.data, dataOut);
        end
      end
      checkValue("overflowFlag", {15'd0, vNow}, {15'd0, V});
    end
  end

  initial begin
    #(watchdogNs);
    failRun($sformatf("Timeout: the program did not reach its halt loop in %0d ns", watchdogNs));
  end

  initial begin
    reset = 1'b1;
    seed  = 47;
    loadProgram();
    repeat (resetCycles) @(posedge Clk1);
    reset <= 1'b0;
    // Done once the halt loop comes around again
    while (fetchQ.size() != 0 || haltFetches == 0) begin
      @(posedge Clk1);
    end
    if (writeQ.size() == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      failRun($sformatf("%0d expected stores never happened, the first one in %s",
                        writeQ.size(), writeNameQ[0]));
    end
  end

endmodule

/* sim/testMemory.sv */
`timescale 1ns/10ps
`include "cvp_defines.svh"

module testMemory (
  input  logic               Clk1,
  input  logic [`WORD_W-1:0] addr,
  input  logic               rd,
  input  logic               wr,
  input  logic [`WORD_W-1:0] wrData,
  output logic [`WORD_W-1:0] rdData
);

  localparam int depth = 1 << `WORD_W; // Whole 16 bit address space

  logic [`WORD_W-1:0] words [depth];

  // Background pattern, so a stray read shows where it came from
  task automatic fill();
    for (int i = 0; i < depth; i++) begin
      words[i] = 16'(i) ^ 16'hA5A5;
    end
    rdData = '0;
  endtask

  task automatic loadWord(input logic [`WORD_W-1:0] a, input logic [`WORD_W-1:0] d);
    words[a] = d;
  endtask

  // Read data shows up the cycle after RD
  always @(posedge Clk1) begin
    if (wr) begin
      words[addr] <= wrData;
    end
    if (rd) begin
      rdData <= words[addr];
    end
  end

endmodule

/* hw/cvpCore.sv */
`timescale 1ns/10ps
`include "cvp_defines.svh"

module cvpCore import cvpPkg::*; (
  input  logic               Clk1,
  input  logic               reset,
  input  logic [`WORD_W-1:0] DataIn,
  output logic [`WORD_W-1:0] Addr,
  output logic [`WORD_W-1:0] dataOut,
  output logic               RD,
  output logic               WR,
  output logic               V
);

  memReqT   memReq;
  regWriteT vecWrite;
  regWriteT scaWrite;

  logic [`REG_ADDR_W-1:0] rdAddr1;
  logic [`REG_ADDR_W-1:0] rdAddr2;
  logic [`REG_ADDR_W-1:0] rdAddr3;

  logic [`VEC_W-1:0]  vecRd1;
  logic [`VEC_W-1:0]  vecRd2;
  logic [`VEC_W-1:0]  vecDst;
  logic [`WORD_W-1:0] scaRd1;
  logic [`WORD_W-1:0] scaDst;

  logic [`WORD_W-1:0] addA;
  logic [`WORD_W-1:0] addB;
  logic [`WORD_W-1:0] sum;
  logic               sumOverflow;

  cvpController u_cvpController (
    .Clk1         (Clk1),
    .reset        (reset),
    .memData      (DataIn),
    .vecRd1       (vecRd1),
    .vecRd2       (vecRd2),
    .vecDst       (vecDst),
    .scaRd1       (scaRd1),
    .scaDst       (scaDst),
    .sum          (sum),
    .sumOverflow  (sumOverflow),
    .memReq       (memReq),
    .overflowFlag (V),
    .rdAddr1      (rdAddr1),
    .rdAddr2      (rdAddr2),
    .rdAddr3      (rdAddr3),
    .vecWrite     (vecWrite),
    .scaWrite     (scaWrite),
    .addA         (addA),
    .addB         (addB)
  );

  vectorRegFile u_vectorRegFile (
    .Clk1    (Clk1),
    .reset   (reset),
    .rdAddr1 (rdAddr1),
    .rdAddr2 (rdAddr2),
    .rdAddr3 (rdAddr3),
    .write   (vecWrite),
    .rdData1 (vecRd1),
    .rdData2 (vecRd2),
    .rdData3 (vecDst)
  );

  // Port 1 is the base address, port 2 the destination
  scalarRegFile u_scalarRegFile (
    .Clk1    (Clk1),
    .reset   (reset),
    .rdAddr1 (rdAddr1),
    .rdAddr2 (rdAddr3),
    .write   (scaWrite),
    .rdData1 (scaRd1),
    .rdData2 (scaDst)
  );

  halfFloatAdd u_halfFloatAdd (
    .a        (addA),
    .b        (addB),
    .sum      (sum),
    .overflow (sumOverflow)
  );

  assign Addr    = memReq.addr;
  assign RD      = memReq.rd;
  assign WR      = memReq.wr;
  assign dataOut = memReq.wrData;

endmodule

/* hw/cvpController.sv */
`timescale 1ns/10ps
`include "cvp_defines.svh"

module cvpController import cvpPkg::*; (
  input  logic                   Clk1,
  input  logic                   reset,
  input  logic [`WORD_W-1:0]     memData,
  input  logic [`VEC_W-1:0]      vecRd1,
  input  logic [`VEC_W-1:0]      vecRd2,
  input  logic [`VEC_W-1:0]      vecDst,
  input  logic [`WORD_W-1:0]     scaRd1,
  input  logic [`WORD_W-1:0]     scaDst,
  input  logic [`WORD_W-1:0]     sum,
  input  logic                   sumOverflow,
  output memReqT                 memReq,
  output logic                   overflowFlag,
  output logic [`REG_ADDR_W-1:0] rdAddr1,
  output logic [`REG_ADDR_W-1:0] rdAddr2,
  output logic [`REG_ADDR_W-1:0] rdAddr3,
  output regWriteT               vecWrite,
  output regWriteT               scaWrite,
  output logic [`WORD_W-1:0]     addA,
  output logic [`WORD_W-1:0]     addB
);

  localparam int memLatency = `MEM_LATENCY;
  localparam int loadCycles = `VEC_LEN + memLatency; // First cycle only issues a read
  localparam int cntW       = $clog2(loadCycles);
  localparam int laneW      = $clog2(`VEC_LEN);

  stateT state;
  stateT nextState;
  instrT instr;

  logic [`WORD_W-1:0] pc;
  logic [cntW-1:0]    laneCnt;
  logic [`VEC_W-1:0]  vecBuf;      // Lanes collected for VADD and VLD
  logic               addOverflow; // Any lane of the running VADD

  logic [laneW-1:0]   lane;
  logic [laneW-1:0]   loadLane;
  logic               lastLane;
  logic               lastLoad;
  logic               loadValid;
  logic [`WORD_W-1:0] baseAddr;
  logic [`WORD_W-1:0] jumpTarget;
  logic [`WORD_W-1:0] byteMerge;

  assign lane      = laneCnt[laneW-1:0];
  assign loadLane  = laneW'(laneCnt - cntW'(memLatency)); // Data trails the read
  assign lastLane  = laneCnt == cntW'(`VEC_LEN - 1);
  assign lastLoad  = laneCnt == cntW'(loadCycles - 1);
  assign loadValid = laneCnt >= cntW'(memLatency);

  assign baseAddr = scaRd1 + instr.f.o.offset;

  // PC already points past the J
  assign jumpTarget = pc - 1'b1 +
                      {{(`WORD_W - 12){instr.f.jumpOffset[11]}}, instr.f.jumpOffset};

  // SLH replaces the high byte, SLL the low byte
  assign byteMerge = (instr.opcode == SLH) ? {instr.f.i.imm, scaDst[7:0]}
                                           : {scaDst[`WORD_W-1:8], instr.f.i.imm};

  assign rdAddr1 = instr.f.r.src1;
  assign rdAddr2 = instr.f.r.src2;
  assign rdAddr3 = instr.f.r.dst;

  assign addA = vecRd1[lane*`WORD_W +: `WORD_W];
  assign addB = vecRd2[lane*`WORD_W +: `WORD_W];

  always_comb begin
    nextState = state;
    case (state)
      Fetch:   nextState = Decode;
      Decode:  nextState = Execute;
      Execute: begin
        case (instr.opcode)
          VADD:     nextState = VectorAdd;
          VLD:      nextState = Load;
          VST, SST: nextState = Store;
          J:        nextState = Jump;
          default:  nextState = WriteBack; // SLL, SLH, NOP
        endcase
      end
      VectorAdd: begin
        if (lastLane) nextState = WriteBack;
      end
      Load: begin
        if (lastLoad) nextState = WriteBack;
      end
      Store: begin
        if (instr.opcode == SST || lastLane) nextState = Fetch;
      end
      Jump:      nextState = Fetch;
      WriteBack: nextState = Fetch;
      default:   nextState = Fetch;
    endcase
  end

  always_ff @(posedge Clk1) begin
    if (reset) begin
      state        <= Fetch;
      pc           <= '0;
      instr.opcode <= NOP;
      instr.f      <= '0;
      laneCnt      <= '0;
      addOverflow  <= 1'b0;
      overflowFlag <= 1'b0;
    end else begin
      state <= nextState;
      case (state)
        Fetch:  pc <= pc + 1'b1;
        Decode: instr <= instrT'(memData);
        Execute: begin
          laneCnt     <= '0;
          addOverflow <= 1'b0;
        end
        VectorAdd: begin
          laneCnt     <= laneCnt + 1'b1;
          addOverflow <= addOverflow | sumOverflow;
        end
        Load:  laneCnt <= laneCnt + 1'b1;
        Store: laneCnt <= laneCnt + 1'b1;
        Jump:  pc <= jumpTarget;
        WriteBack: begin
          // Flag shows from the next fetch on
          if (instr.opcode == VADD) overflowFlag <= addOverflow;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge Clk1) begin
    if (state == VectorAdd) begin
      vecBuf[lane*`WORD_W +: `WORD_W] <= sum;
    end else if (state == Load && loadValid) begin
      vecBuf[loadLane*`WORD_W +: `WORD_W] <= memData;
    end
  end

  always_comb begin
    memReq = '0;
    case (state)
      Fetch: begin
        memReq.rd   = 1'b1;
        memReq.addr = pc;
      end
      Load: begin
        memReq.rd   = laneCnt < cntW'(`VEC_LEN); // Last cycle only collects
        memReq.addr = baseAddr + laneCnt;
      end
      Store: begin
        memReq.wr     = 1'b1;
        memReq.addr   = baseAddr + laneCnt;
        memReq.wrData = (instr.opcode == SST) ? scaDst : vecDst[lane*`WORD_W +: `WORD_W];
      end
      default: ;
    endcase
  end

  always_comb begin
    vecWrite = '0;
    scaWrite = '0;
    if (state == WriteBack) begin
      case (instr.opcode)
        VADD, VLD: begin
          vecWrite.en   = 1'b1;
          vecWrite.addr = instr.f.r.dst;
          vecWrite.data = vecBuf;
        end
        SLL, SLH: begin
          scaWrite.en                 = 1'b1;
          scaWrite.addr               = instr.f.r.dst;
          scaWrite.data[`WORD_W-1:0]  = byteMerge;
        end
        default: ; // NOP writes nothing
      endcase
    end
  end

endmodule

/* hw/halfFloatAdd.sv */
`timescale 1ns/10ps
`include "cvp_defines.svh"

module halfFloatAdd (
  input  logic [`WORD_W-1:0] a,
  input  logic [`WORD_W-1:0] b,
  output logic [`WORD_W-1:0] sum,
  output logic               overflow
);

  logic               aBigger;
  logic [`WORD_W-1:0] opBig;
  logic [`WORD_W-1:0] opSmall;
  logic [4:0]         expBig;
  logic [4:0]         expSmall;
  logic [4:0]         diff;
  logic [10:0]        sigBig;
  logic [10:0]        sigSmall;
  logic [30:0]        smallWide;
  logic [13:0]        mantBig;
  logic [13:0]        mantSmall;
  logic [14:0]        raw;
  logic [3:0]         leadZeros;
  logic [4:0]         maxShift;
  logic [3:0]         shiftAmt;
  logic [13:0]        leftNorm;
  logic [13:0]        norm;
  logic [5:0]         expNorm;
  logic               roundUp;
  logic [15:0]        rounded;
  logic               anyInf;
  logic               isZero;
  logic               resSign;

  // Leading zeros of a 14 bit significand, 14 when all clear
  function automatic logic [3:0] lzc14(input logic [13:0] v);
    logic [3:0] n;
    logic       found;
    n     = 4'd14;
    found = 1'b0;
    for (int i = 13; i >= 0; i--) begin
      if (!found && v[i]) begin
        n     = 4'(13 - i);
        found = 1'b1;
      end
    end
    return n;
  endfunction

  // Order by magnitude
  assign aBigger = a[14:0] >= b[14:0];
  assign opBig   = aBigger ? a : b;
  assign opSmall = aBigger ? b : a;

  // Subnormals sit at exponent 1 without the hidden bit
  assign expBig   = (opBig[14:10] == 5'd0) ? 5'd1 : opBig[14:10];
  assign expSmall = (opSmall[14:10] == 5'd0) ? 5'd1 : opSmall[14:10];
  assign sigBig   = {|opBig[14:10], opBig[9:0]};
  assign sigSmall = {|opSmall[14:10], opSmall[9:0]};

  // Align smaller operand, guard and round kept, rest folded into sticky
  assign diff      = expBig - expSmall;
  assign smallWide = {sigSmall, 20'd0} >> diff;
  assign mantBig   = {sigBig, 3'b000};
  assign mantSmall = {smallWide[30:18], |smallWide[17:0]};

  assign raw = (a[15] ^ b[15]) ? {1'b0, mantBig} - {1'b0, mantSmall}
                               : {1'b0, mantBig} + {1'b0, mantSmall};

  // Left shift stops at the subnormal boundary
  assign leadZeros = lzc14(raw[13:0]);
  assign maxShift  = expBig - 5'd1;
  assign shiftAmt  = ({1'b0, leadZeros} > maxShift) ? maxShift[3:0] : leadZeros;
  assign leftNorm  = raw[13:0] << shiftAmt;

  always_comb begin
    if (raw[14]) begin
      norm    = {raw[14:2], raw[1] | raw[0]}; // Carry out, shift right
      expNorm = {1'b0, expBig} + 6'd1;
    end else begin
      norm    = leftNorm;
      expNorm = leftNorm[13] ? {1'b0, expBig} - {2'b00, shiftAmt} : 6'd0;
    end
  end

  // Nearest even; a mantissa carry rolls into the exponent
  assign roundUp = norm[2] & (norm[1] | norm[0] | norm[3]);
  assign rounded = {expNorm, norm[12:3]} + {15'd0, roundUp};

  assign anyInf   = (&a[14:10]) | (&b[14:10]);
  assign overflow = anyInf | (rounded[15:10] >= 6'd31);

  // Exact cancellation gives +0
  assign isZero  = raw == 15'd0;
  assign resSign = isZero ? (a[15] & b[15]) : opBig[15];

  assign sum = overflow ? (`HALF_INF | {opBig[15], 15'd0})
                        : {resSign, rounded[14:0]};

endmodule

/* hw/scalarRegFile.sv */
`timescale 1ns/10ps
`include "cvp_defines.svh"

module scalarRegFile import cvpPkg::*; (
  input  logic                   Clk1,
  input  logic                   reset,
  input  logic [`REG_ADDR_W-1:0] rdAddr1,
  input  logic [`REG_ADDR_W-1:0] rdAddr2,
  input  regWriteT               write,
  output logic [`WORD_W-1:0]     rdData1,
  output logic [`WORD_W-1:0]     rdData2
);

  logic [`WORD_W-1:0] regs [`NUM_REGS];

  always_ff @(posedge Clk1) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write.en) begin
      regs[write.addr] <= write.data[`WORD_W-1:0]; // Upper bits unused here
    end
  end

  assign rdData1 = regs[rdAddr1]; // Base address
  assign rdData2 = regs[rdAddr2]; // Destination, for SST and byte merges

endmodule

/* hw/vectorRegFile.sv */
`timescale 1ns/10ps
`include "cvp_defines.svh"

module vectorRegFile import cvpPkg::*; (
  input  logic                   Clk1,
  input  logic                   reset,
  input  logic [`REG_ADDR_W-1:0] rdAddr1,
  input  logic [`REG_ADDR_W-1:0] rdAddr2,
  input  logic [`REG_ADDR_W-1:0] rdAddr3,
  input  regWriteT               write,
  output logic [`VEC_W-1:0]      rdData1,
  output logic [`VEC_W-1:0]      rdData2,
  output logic [`VEC_W-1:0]      rdData3
);

  logic [`VEC_W-1:0] regs [`NUM_REGS];

  always_ff @(posedge Clk1) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write.en) begin
      regs[write.addr] <= write.data;
    end
  end

  // Reads see the old value during a write
  assign rdData1 = regs[rdAddr1];
  assign rdData2 = regs[rdAddr2];
  assign rdData3 = regs[rdAddr3]; // VST source

endmodule

/* hw/cvpPkg.sv */
`include "cvp_defines.svh"

package cvpPkg;

  // Unlisted codes fall through as NOP
  typedef enum logic [3:0] {
    VADD = 4'h0,
    SST  = 4'h3,
    VLD  = 4'h4,
    VST  = 4'h5,
    SLL  = 4'h6,
    SLH  = 4'h7,
    J    = 4'h8,
    NOP  = 4'hF
  } opcodeT;

  typedef enum logic [2:0] {
    Fetch,
    Decode,
    Execute,
    VectorAdd,
    Load,
    Store,
    Jump,
    WriteBack
  } stateT;

  // Views of instruction bits [11:0]
  typedef struct packed {
    logic [2:0] dst;   // [11:9]
    logic [2:0] src1;  // [8:6]
    logic [2:0] src2;  // [5:3]
    logic [2:0] spare; // [2:0]
  } regFieldsT;

  typedef struct packed {
    logic [3:0] spare;
    logic [7:0] imm;   // [7:0]
  } immFieldsT;

  typedef struct packed {
    logic [5:0] spare;
    logic [5:0] offset; // [5:0], zero-extended
  } offFieldsT;

  typedef union packed {
    regFieldsT  r;
    immFieldsT  i;
    offFieldsT  o;
    logic [11:0] jumpOffset; // Signed, relative to the J itself
  } operandT;

  typedef struct packed {
    opcodeT  opcode; // [15:12]
    operandT f;
  } instrT;

  typedef struct packed {
    logic [`WORD_W-1:0] addr;
    logic               rd;
    logic               wr;
    logic [`WORD_W-1:0] wrData;
  } memReqT;

  // Scalar file takes the low WORD_W bits of data
  typedef struct packed {
    logic                  en;
    logic [`REG_ADDR_W-1:0] addr;
    logic [`VEC_W-1:0]     data;
  } regWriteT;

endpackage

/* hw/cvp_defines.svh */
`ifndef CVP_DEFINES_SVH
`define CVP_DEFINES_SVH

// Data, address, instruction and scalar width
`define WORD_W 16

// Lanes per vector register
`define VEC_LEN 4
`define VEC_W (`WORD_W * `VEC_LEN)

// Register file addressing, eight entries per file
`define REG_ADDR_W 3
`define NUM_REGS (1 << `REG_ADDR_W)

// Cycles from RD to valid DataIn
`define MEM_LATENCY 1

// Half precision +infinity
`define HALF_INF 16'h7C00

`endif
